// File: rtl/ctrl_pkg.sv
// Controller types, joystick bit map, PS/2 scan codes and keypad line codes
package ctrl_pkg;

    // ========================================================================
    // Sizes and types
    // ========================================================================

    localparam int NUM_PLAYERS = 2;          // Two controller ports

    // One PS/2 key event from the host
    typedef struct packed {
        logic       strobe;                  // Valid for one cycle
        logic       pressed;                 // 1 make, 0 break
        logic       extended;                // E0 prefix seen
        logic [7:0] code;                    // Set 2 scan code
    } key_event_t;

    typedef logic [31:0] joy_word_t;         // Host joystick word, bits 19:0 used

    // Bit positions inside a host joystick word
    localparam int JOY_RIGHT  = 0;
    localparam int JOY_LEFT   = 1;
    localparam int JOY_DOWN   = 2;
    localparam int JOY_UP     = 3;
    localparam int JOY_FIRE1  = 4;
    localparam int JOY_FIRE2  = 5;
    localparam int JOY_STAR   = 6;
    localparam int JOY_NUMBER = 7;
    localparam int JOY_DIGIT0 = 8;           // Digits 0..9 on bits 8..17
    localparam int JOY_PURPLE = 18;
    localparam int JOY_BLUE   = 19;

    // Requests of one player, active high
    typedef struct packed {
        logic [9:0] digit;                   // Index is the digit value
        logic       star;
        logic       number;
        logic       purple;
        logic       blue;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
        logic       fire1;
        logic       fire2;
    } keypad_vec_t;

    // Port lines of one player, active low
    typedef struct packed {
        logic [3:0] line_n;
        logic       button_n;
    } port_out_t;

    // ========================================================================
    // PS/2 set 2 scan codes
    // ========================================================================

    // Main row digits
    localparam logic [7:0] SC_MAIN_1 = 8'h16;
    localparam logic [7:0] SC_MAIN_2 = 8'h1E;
    localparam logic [7:0] SC_MAIN_3 = 8'h26;
    localparam logic [7:0] SC_MAIN_4 = 8'h25;
    localparam logic [7:0] SC_MAIN_5 = 8'h2E;
    localparam logic [7:0] SC_MAIN_6 = 8'h36;
    localparam logic [7:0] SC_MAIN_7 = 8'h3D;
    localparam logic [7:0] SC_MAIN_8 = 8'h3E;
    localparam logic [7:0] SC_MAIN_9 = 8'h46;
    localparam logic [7:0] SC_MAIN_0 = 8'h45;

    // Numeric pad digits
    localparam logic [7:0] SC_PAD_1 = 8'h69;
    localparam logic [7:0] SC_PAD_2 = 8'h72;
    localparam logic [7:0] SC_PAD_3 = 8'h7A;
    localparam logic [7:0] SC_PAD_4 = 8'h6B;
    localparam logic [7:0] SC_PAD_5 = 8'h73;
    localparam logic [7:0] SC_PAD_6 = 8'h74;
    localparam logic [7:0] SC_PAD_7 = 8'h6C;
    localparam logic [7:0] SC_PAD_8 = 8'h75;
    localparam logic [7:0] SC_PAD_9 = 8'h7D;
    localparam logic [7:0] SC_PAD_0 = 8'h70;

    localparam logic [7:0] SC_STAR      = 8'h7C;
    localparam logic [7:0] SC_PAD_MINUS = 8'h7B;   // Stands in for number
    localparam logic [7:0] SC_LSHIFT    = 8'h12;
    localparam logic [7:0] SC_RSHIFT    = 8'h59;

    // ========================================================================
    // Keypad line codes seen by the console
    // ========================================================================

    localparam logic [3:0] KEY_0      = 4'b0011;
    localparam logic [3:0] KEY_1      = 4'b1110;
    localparam logic [3:0] KEY_2      = 4'b1101;
    localparam logic [3:0] KEY_3      = 4'b0110;
    localparam logic [3:0] KEY_4      = 4'b0001;
    localparam logic [3:0] KEY_5      = 4'b1001;
    localparam logic [3:0] KEY_6      = 4'b0111;
    localparam logic [3:0] KEY_7      = 4'b1100;
    localparam logic [3:0] KEY_8      = 4'b1000;
    localparam logic [3:0] KEY_9      = 4'b1011;
    localparam logic [3:0] KEY_STAR   = 4'b1010;
    localparam logic [3:0] KEY_NUMBER = 4'b0101;
    localparam logic [3:0] KEY_PURPLE = 4'b0100;
    localparam logic [3:0] KEY_BLUE   = 4'b0010;
    localparam logic [3:0] KEY_NONE   = 4'b1111;

endpackage

// File: rtl/ps2_keypad_tracker.sv
// PS/2 key event tracker holding the pressed state of the emulated keypad keys
`timescale 1ns/100ps

module ps2_keypad_tracker
    import ctrl_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_n_i,
    input  key_event_t  key_event_i,
    output keypad_vec_t kbd_vec_o
);

    logic [9:0] digit_q;                     // One bit per digit key
    logic       star_q;
    logic       minus_q;
    logic       shift_q;                     // Either shift key

    // ========================================================================
    // Key state registers
    // ========================================================================

    // Extended flag is not decoded, E0 variants fold onto the plain keys
    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            digit_q <= '0;
            star_q  <= 1'b0;
            minus_q <= 1'b0;
            shift_q <= 1'b0;
        end else if (key_event_i.strobe) begin
            case (key_event_i.code)
                SC_MAIN_0, SC_PAD_0: digit_q[0] <= key_event_i.pressed;
                SC_MAIN_1, SC_PAD_1: digit_q[1] <= key_event_i.pressed;
                SC_MAIN_2, SC_PAD_2: digit_q[2] <= key_event_i.pressed;
                SC_MAIN_3, SC_PAD_3: digit_q[3] <= key_event_i.pressed;
                SC_MAIN_4, SC_PAD_4: digit_q[4] <= key_event_i.pressed;
                SC_MAIN_5, SC_PAD_5: digit_q[5] <= key_event_i.pressed;
                SC_MAIN_6, SC_PAD_6: digit_q[6] <= key_event_i.pressed;
                SC_MAIN_7, SC_PAD_7: digit_q[7] <= key_event_i.pressed;
                SC_MAIN_8, SC_PAD_8: digit_q[8] <= key_event_i.pressed;
                SC_MAIN_9, SC_PAD_9: digit_q[9] <= key_event_i.pressed;
                SC_STAR:             star_q     <= key_event_i.pressed;
                SC_PAD_MINUS:        minus_q    <= key_event_i.pressed;
                SC_LSHIFT, SC_RSHIFT: begin
                    shift_q <= key_event_i.pressed;    // Last shift event wins
                end
                default: ;                             // Other keys ignored
            endcase
        end
    end

    // ========================================================================
    // Keypad vector
    // ========================================================================

    always_comb begin
        kbd_vec_o        = '0;               // Directions and fire never set here
        kbd_vec_o.digit  = digit_q;
        // Shift+8 and shift+3 follow the US layout for * and #
        kbd_vec_o.star   = star_q  | (shift_q & digit_q[8]);
        kbd_vec_o.number = minus_q | (shift_q & digit_q[3]);
    end

endmodule

// File: rtl/joystick_mapper.sv
// Host joystick registers, player swap and reorder into keypad vectors
`timescale 1ns/100ps

module joystick_mapper
    import ctrl_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_n_i,
    input  joy_word_t   joy0_i,
    input  joy_word_t   joy1_i,
    input  logic        swap_i,
    output keypad_vec_t joy_vec_o [NUM_PLAYERS]
);

    joy_word_t joy0_q;
    joy_word_t joy1_q;
    logic      swap_q;

    // Host word bit order into keypad fields
    function automatic keypad_vec_t map_word(joy_word_t w);
        keypad_vec_t v;
        v        = '0;
        v.digit  = w[JOY_DIGIT0 +: 10];
        v.star   = w[JOY_STAR];
        v.number = w[JOY_NUMBER];
        v.purple = w[JOY_PURPLE];
        v.blue   = w[JOY_BLUE];
        v.up     = w[JOY_UP];
        v.down   = w[JOY_DOWN];
        v.left   = w[JOY_LEFT];
        v.right  = w[JOY_RIGHT];
        v.fire1  = w[JOY_FIRE1];
        v.fire2  = w[JOY_FIRE2];
        return v;
    endfunction

    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            joy0_q <= '0;
            joy1_q <= '0;
            swap_q <= 1'b0;
        end else begin
            joy0_q <= joy0_i;
            joy1_q <= joy1_i;
            swap_q <= swap_i;
        end
    end

    // Entry 0 is player 1
    assign joy_vec_o[0] = map_word(swap_q ? joy1_q : joy0_q);
    assign joy_vec_o[1] = map_word(swap_q ? joy0_q : joy1_q);

endmodule

// File: rtl/controller_port_encoder.sv
// Keyboard and joystick merge with keypad and direction encoding per port
`timescale 1ns/100ps

module controller_port_encoder
    import ctrl_pkg::*;
(
    input  keypad_vec_t             kbd_vec_i,
    input  keypad_vec_t             joy_vec_i [NUM_PLAYERS],
    input  logic [NUM_PLAYERS-1:0]  keypad_sel_n_i,   // Low selects keypad side
    input  logic [NUM_PLAYERS-1:0]  joy_sel_n_i,      // Low selects stick side
    output port_out_t               port_o [NUM_PLAYERS]
);

    // ========================================================================
    // Keypad priority encoder
    // ========================================================================

    // Lowest priority is assigned first so later matches override it.
    // Final order is digit 0, digits 1..9, star, number, purple, blue.
    function automatic logic [3:0] keypad_code(keypad_vec_t v);
        logic [3:0] code;
        code = KEY_NONE;
        if (v.blue)     code = KEY_BLUE;
        if (v.purple)   code = KEY_PURPLE;
        if (v.number)   code = KEY_NUMBER;
        if (v.star)     code = KEY_STAR;
        if (v.digit[9]) code = KEY_9;
        if (v.digit[8]) code = KEY_8;
        if (v.digit[7]) code = KEY_7;
        if (v.digit[6]) code = KEY_6;
        if (v.digit[5]) code = KEY_5;
        if (v.digit[4]) code = KEY_4;
        if (v.digit[3]) code = KEY_3;
        if (v.digit[2]) code = KEY_2;
        if (v.digit[1]) code = KEY_1;
        if (v.digit[0]) code = KEY_0;
        return code;
    endfunction

    // ========================================================================
    // Per player port lines
    // ========================================================================

    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
        keypad_vec_t merged;
        logic [3:0]  pad_line_n;
        logic [3:0]  joy_line_n;
        logic        pad_button_n;
        logic        joy_button_n;

        // Keyboard feeds every player
        assign merged = keypad_vec_t'(joy_vec_i[p] | kbd_vec_i);

        // Keypad side
        always_comb begin
            pad_line_n   = 4'b1111;
            pad_button_n = 1'b1;
            if (!keypad_sel_n_i[p]) begin
                pad_line_n   = keypad_code(merged);
                pad_button_n = ~merged.fire2;    // Right button
            end
        end

        // Direction side
        always_comb begin
            joy_line_n   = 4'b1111;
            joy_button_n = 1'b1;
            if (!joy_sel_n_i[p]) begin
                joy_line_n   = ~{merged.up, merged.down, merged.left, merged.right};
                joy_button_n = ~merged.fire1;    // Left button
            end
        end

        // Open collector style wired AND of both sides
        assign port_o[p].line_n   = pad_line_n & joy_line_n;
        assign port_o[p].button_n = pad_button_n & joy_button_n;
    end

endmodule

// File: rtl/controller_input_top.sv
// Controller input top level with key tracker, joystick mapper and port encoder
`timescale 1ns/100ps

module controller_input_top
    import ctrl_pkg::*;
(
    input  logic                    clk_sys,
    input  logic                    rst_n_i,
    input  key_event_t              key_event_i,
    input  joy_word_t               joy0_i,
    input  joy_word_t               joy1_i,
    input  logic                    swap_i,          // Exchange players 1 and 2
    input  logic [NUM_PLAYERS-1:0]  keypad_sel_n_i,  // Console ctrl_p5 lines
    input  logic [NUM_PLAYERS-1:0]  joy_sel_n_i,     // Console ctrl_p8 lines
    output port_out_t               port_o [NUM_PLAYERS]
);

    keypad_vec_t kbd_vec;
    keypad_vec_t joy_vec [NUM_PLAYERS];

    // ========================================================================
    // Sources
    // ========================================================================

    ps2_keypad_tracker ps2_keypad_tracker_inst (
        .clk_sys     (clk_sys),
        .rst_n_i     (rst_n_i),
        .key_event_i (key_event_i),
        .kbd_vec_o   (kbd_vec)
    );

    joystick_mapper joystick_mapper_inst (
        .clk_sys   (clk_sys),
        .rst_n_i   (rst_n_i),
        .joy0_i    (joy0_i),
        .joy1_i    (joy1_i),
        .swap_i    (swap_i),
        .joy_vec_o (joy_vec)
    );

    // ========================================================================
    // Port lines
    // ========================================================================

    controller_port_encoder controller_port_encoder_inst (
        .kbd_vec_i      (kbd_vec),
        .joy_vec_i      (joy_vec),
        .keypad_sel_n_i (keypad_sel_n_i),
        .joy_sel_n_i    (joy_sel_n_i),
        .port_o         (port_o)
    );

endmodule

// File: sim/controller_input_checker.sv
// Concurrent assertions on the controller input top level ports and their bind
`timescale 1ns/100ps

module controller_input_checker
    import ctrl_pkg::*;
(
    input logic                   clk_sys,
    input logic                   rst_n_i,
    input key_event_t             key_event_i,
    input joy_word_t              joy0_i,
    input joy_word_t              joy1_i,
    input logic                   swap_i,
    input logic [NUM_PLAYERS-1:0] keypad_sel_n_i,
    input logic [NUM_PLAYERS-1:0] joy_sel_n_i,
    input port_out_t              port_o [NUM_PLAYERS]
);

    int   fail_count = 0;                       // Failed assertion count
    logic key_seen;                             // Any strobe since reset

    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            key_seen <= 1'b0;
        end else if (key_event_i.strobe) begin
            key_seen <= 1'b1;
        end
    end

    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
        // Neither side selected
        a_idle_high: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
            (keypad_sel_n_i[p] && joy_sel_n_i[p]) |-> (port_o[p] == 5'b11111))
        else begin
            fail_count++;
            $error("Player %0d port not all ones with both selects high", p);
        end

        // Registered sources unchanged over the last two samples
        a_port_held: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
            (!$past(key_event_i.strobe) && $past(joy0_i) == $past(joy0_i, 2)
             && $past(joy1_i) == $past(joy1_i, 2) && $past(swap_i) == $past(swap_i, 2)
             && $stable(keypad_sel_n_i) && $stable(joy_sel_n_i)) |-> $stable(port_o[p]))
        else begin
            fail_count++;
            $error("Player %0d port changed without a key event or input change", p);
        end

        a_none_after_reset: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
            (!key_seen && $past(joy0_i) == '0 && $past(joy1_i) == '0)
            |-> (port_o[p].line_n == KEY_NONE))
        else begin
            fail_count++;
            $error("Player %0d line nibble not idle before any input", p);
        end
    end

endmodule

bind controller_input_top controller_input_checker controller_input_checker_inst (
    .clk_sys        (clk_sys),
    .rst_n_i        (rst_n_i),
    .key_event_i    (key_event_i),
    .joy0_i         (joy0_i),
    .joy1_i         (joy1_i),
    .swap_i         (swap_i),
    .keypad_sel_n_i (keypad_sel_n_i),
    .joy_sel_n_i    (joy_sel_n_i),
    .port_o         (port_o)
);

// File: sim/tb_controller_input.sv
// Testbench with clock, reset, seeded random stimulus, reference model and result checks
`timescale 1ns/100ps

module tb_controller_input
    import ctrl_pkg::*;
();

    // ========================================================================
    // Run lengths and lookup tables
    // ========================================================================

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DLY    = 2;            // Inputs change after the edge
    localparam int RESET_CYCLES = 16;
    localparam int N_SEL        = 16;           // All select combinations
    localparam int N_KEY        = 300;
    localparam int N_RELEASE    = 13;
    localparam int N_JOY        = 200;
    localparam int N_DIR        = 200;
    localparam int N_BOTH       = 100;
    localparam int N_MIX        = 2000;
    localparam int TOTAL_CYCLES = RESET_CYCLES + N_SEL + N_KEY + N_RELEASE + N_JOY
                                + N_DIR + N_BOTH + N_MIX + 4;
    localparam int CYCLE_LIMIT  = TOTAL_CYCLES + TOTAL_CYCLES / 10;

    localparam logic [7:0] MAIN_CODES [10] = '{SC_MAIN_0, SC_MAIN_1, SC_MAIN_2, SC_MAIN_3,
        SC_MAIN_4, SC_MAIN_5, SC_MAIN_6, SC_MAIN_7, SC_MAIN_8, SC_MAIN_9};
    localparam logic [7:0] PAD_CODES [10] = '{SC_PAD_0, SC_PAD_1, SC_PAD_2, SC_PAD_3,
        SC_PAD_4, SC_PAD_5, SC_PAD_6, SC_PAD_7, SC_PAD_8, SC_PAD_9};
    // Highest priority first
    localparam logic [3:0] PRIO_CODES [14] = '{KEY_0, KEY_1, KEY_2, KEY_3, KEY_4,
        KEY_5, KEY_6, KEY_7, KEY_8, KEY_9, KEY_STAR, KEY_NUMBER, KEY_PURPLE, KEY_BLUE};

    logic                   clk_sys;
    logic                   rst_n;
    key_event_t             key_event;
    joy_word_t              joy0;
    joy_word_t              joy1;
    logic                   swap;
    logic [NUM_PLAYERS-1:0] keypad_sel_n;
    logic [NUM_PLAYERS-1:0] joy_sel_n;
    port_out_t              port [NUM_PLAYERS];

    integer seed;
    int     error_count;
    int     check_count;
    int     cycle_count = 0;

    // Model state
    logic [12:0] m_keys;                        // 9:0 digits, 10 star, 11 minus, 12 shift
    joy_word_t   m_joy0;
    joy_word_t   m_joy1;
    logic        m_swap;

    controller_input_top controller_input_top_inst (
        .clk_sys        (clk_sys),
        .rst_n_i        (rst_n),
        .key_event_i    (key_event),
        .joy0_i         (joy0),
        .joy1_i         (joy1),
        .swap_i         (swap),
        .keypad_sel_n_i (keypad_sel_n),
        .joy_sel_n_i    (joy_sel_n),
        .port_o         (port)
    );

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the test sequence did not complete",
                     cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ========================================================================
    // Reference model
    // ========================================================================

    // Key state slot for a scan code, -1 when the key is not emulated
    function automatic int key_index(logic [7:0] code);
        int idx;
        int d;
        idx = -1;
        for (d = 0; d < 10; d++) begin
            if (code == MAIN_CODES[d] || code == PAD_CODES[d]) idx = d;
        end
        if (code == SC_STAR) idx = 10;
        if (code == SC_PAD_MINUS) idx = 11;
        if (code == SC_LSHIFT || code == SC_RSHIFT) idx = 12;
        return idx;
    endfunction

    always @(posedge clk_sys or negedge rst_n) begin : model_update
        int idx;
        if (!rst_n) begin
            m_keys <= '0;
            m_joy0 <= '0;
            m_joy1 <= '0;
            m_swap <= 1'b0;
        end else begin
            idx = key_index(key_event.code);
            if (key_event.strobe && idx >= 0) m_keys[idx] <= key_event.pressed;
            m_joy0 <= joy0;
            m_joy1 <= joy1;
            m_swap <= swap;
        end
    end

    function automatic port_out_t expected_port(int p);
        joy_word_t   w;
        logic [13:0] req;                       // Bit index is the priority rank
        logic [3:0]  pad_n;
        logic [3:0]  dir_n;
        logic        pad_b;
        logic        dir_b;
        logic        kbd_star;
        logic        kbd_num;
        logic        found;
        int          i;
        port_out_t   r;
        w        = ((p == 0) != m_swap) ? m_joy0 : m_joy1;
        kbd_star = m_keys[10] | (m_keys[12] & m_keys[8]);
        kbd_num  = m_keys[11] | (m_keys[12] & m_keys[3]);
        req      = {w[19], w[18], w[7] | kbd_num, w[6] | kbd_star, w[17:8] | m_keys[9:0]};
        pad_n    = 4'b1111;
        pad_b    = 1'b1;
        dir_n    = 4'b1111;
        dir_b    = 1'b1;
        if (!keypad_sel_n[p]) begin
            pad_n = KEY_NONE;
            found = 1'b0;
            for (i = 0; i < 14; i++) begin
                if (req[i] && !found) begin
                    pad_n = PRIO_CODES[i];
                    found = 1'b1;
                end
            end
            pad_b = ~w[5];                      // Fire 2
        end
        if (!joy_sel_n[p]) begin
            dir_n = ~w[3:0];                    // Up, down, left, right
            dir_b = ~w[4];
        end
        r.line_n   = pad_n & dir_n;
        r.button_n = pad_b & dir_b;
        return r;
    endfunction

    // ========================================================================
    // Compare and stimulus helpers
    // ========================================================================

    task automatic compare_port(string name, int p, port_out_t exp, port_out_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAILED %s player %0d: expected %b, actual %b (line_n, button_n)",
                     name, p, exp, act);
        end
    endtask

    task automatic compare_vec_line(string name, int p, logic [3:0] exp, logic [3:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAILED %s player %0d: expected line_n %b, actual line_n %b",
                     name, p, exp, act);
        end
    endtask

    task automatic check_ports(string name, bit line_only);
        port_out_t exp;
        int        p;
        @(negedge clk_sys);                     // Mid cycle, outputs settled
        for (p = 0; p < NUM_PLAYERS; p++) begin
            exp = expected_port(p);
            if (line_only) compare_vec_line(name, p, exp.line_n, port[p].line_n);
            else compare_port(name, p, exp, port[p]);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_sys);
        #DRIVE_DLY;
        key_event.strobe = 1'b0;                // Strobe lasts one cycle
    endtask

    function automatic joy_word_t sparse_word();
        return $random(seed) & $random(seed) & $random(seed);
    endfunction

    task automatic drive_random_key();
        int sel;
        sel = $unsigned($random(seed)) % 32;
        key_event.strobe   = 1'b1;
        key_event.pressed  = (($random(seed) & 3) == 0);   // Mostly releases
        key_event.extended = 1'($random(seed));
        if (sel < 10) key_event.code = MAIN_CODES[sel];
        else if (sel < 20) key_event.code = PAD_CODES[sel - 10];
        else if (sel == 20) key_event.code = SC_STAR;
        else if (sel == 21) key_event.code = SC_PAD_MINUS;
        else if (sel == 22) key_event.code = SC_LSHIFT;
        else if (sel == 23) key_event.code = SC_RSHIFT;
        else key_event.code = 8'($random(seed));  // Any code, usually unmatched
    endtask

    // ========================================================================
    // Tests
    // ========================================================================

    task automatic test_after_reset();
        int s;
        for (s = 0; s < N_SEL; s++) begin
            next_cycle();
            keypad_sel_n = s[1:0];
            joy_sel_n    = s[3:2];
            check_ports("after_reset", 1'b0);
        end
    endtask

    task automatic test_keyboard_keypad();
        int n;
        int k;
        for (n = 0; n < N_KEY; n++) begin
            next_cycle();
            keypad_sel_n = '0;
            joy_sel_n    = '1;
            if (($random(seed) & 3) != 0) drive_random_key();
            check_ports("keyboard_keypad", 1'b1);
        end
        // Break codes for every tracked key
        for (k = 0; k < N_RELEASE; k++) begin
            next_cycle();
            key_event.strobe  = 1'b1;
            key_event.pressed = 1'b0;
            key_event.code    = (k < 10) ? MAIN_CODES[k] : (k == 10) ? SC_STAR :
                                (k == 11) ? SC_PAD_MINUS : SC_LSHIFT;
            check_ports("keyboard_release", 1'b1);
        end
    endtask

    task automatic test_joystick(string name, bit dirs, int count);
        int n;
        for (n = 0; n < count; n++) begin
            next_cycle();
            keypad_sel_n = dirs ? 2'b11 : 2'b00;
            joy_sel_n    = dirs ? 2'b00 : 2'b11;
            joy0         = dirs ? $random(seed) : sparse_word();
            joy1         = dirs ? $random(seed) : sparse_word();
            swap         = 1'($random(seed));
            check_ports(name, 1'b0);
        end
    endtask

    task automatic test_random_mix();
        int n;
        for (n = 0; n < N_BOTH + N_MIX; n++) begin
            next_cycle();
            keypad_sel_n = (n < N_BOTH) ? 2'b00 : 2'($random(seed));
            joy_sel_n    = (n < N_BOTH) ? 2'b00 : 2'($random(seed));
            joy0         = sparse_word();
            joy1         = sparse_word();
            swap         = 1'($random(seed));
            if (n >= N_BOTH && ($random(seed) & 1)) drive_random_key();
            check_ports((n < N_BOTH) ? "both_selects" : "random_mix", 1'b0);
        end
    endtask

    initial begin
        seed         = 5303;
        error_count  = 0;
        check_count  = 0;
        rst_n        = 1'b0;
        key_event    = '0;
        joy0         = '0;
        joy1         = '0;
        swap         = 1'b0;
        keypad_sel_n = '1;
        joy_sel_n    = '1;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        #DRIVE_DLY;
        rst_n = 1'b1;

        test_after_reset();
        test_keyboard_keypad();
        test_joystick("joystick_keypad", 1'b0, N_JOY);
        test_joystick("joystick_directions", 1'b1, N_DIR);
        test_random_mix();
        next_cycle();                           // Last registered update
        check_ports("final", 1'b0);

        $display("Checks: %0d, value errors: %0d, assertion errors: %0d", check_count,
                 error_count, controller_input_top_inst.controller_input_checker_inst.fail_count);
        if (error_count + controller_input_top_inst.controller_input_checker_inst.fail_count > 0)
            $display("ERRORS FOUND");
        else
            $display("NO ERRORS");
        $finish;
    end

endmodule

// File: files.f
rtl/ctrl_pkg.sv
rtl/ps2_keypad_tracker.sv
rtl/joystick_mapper.sv
rtl/controller_port_encoder.sv
rtl/controller_input_top.sv
sim/controller_input_checker.sv
sim/tb_controller_input.sv

// File: Bender.yml
package:
  name: controller_input

sources:
  - files:
      - rtl/ctrl_pkg.sv
      - rtl/ps2_keypad_tracker.sv
      - rtl/joystick_mapper.sv
      - rtl/controller_port_encoder.sv
      - rtl/controller_input_top.sv
  - target: test
    files:
      - sim/controller_input_checker.sv
      - sim/tb_controller_input.sv
